/* hw/dec_gpr_ctl.sv */
/*
 * dec_gpr_ctl: architectural register file, x0 hardwired to zero
 * four combinational read ports, three write ports (i1 > i0 > nb load)
 */

module dec_gpr_ctl (
   input  logic               clk,
   input  logic               rst_n,

   input  logic               rden0,       // i0 rs1
   input  dec_pkg::reg_addr_t raddr0,
   input  logic               rden1,       // i0 rs2
   input  dec_pkg::reg_addr_t raddr1,
   input  logic               rden2,       // i1 rs1
   input  dec_pkg::reg_addr_t raddr2,
   input  logic               rden3,       // i1 rs2
   input  dec_pkg::reg_addr_t raddr3,

   output dec_pkg::xlen_t     rd0,
   output dec_pkg::xlen_t     rd1,
   output dec_pkg::xlen_t     rd2,
   output dec_pkg::xlen_t     rd3,

   gpr_wr_if.gpr              wr,          // slot writes from wb

   input  logic               nb_wen,      // nonblock load return
   input  dec_pkg::reg_addr_t nb_waddr,
   input  dec_pkg::xlen_t     nb_wdata
);

   dec_pkg::xlen_t gpr_q [dec_pkg::NUM_GPR];   // entry 0 is a tie-off

   // ******************************
   // storage and write priority
   // ******************************
   for (genvar i = 0; i < dec_pkg::NUM_GPR; i++) begin : g_gpr
      if (i == 0) begin : g_x0
         assign gpr_q[i] = '0;                   // x0 reads zero
      end else begin : g_xn
         logic w0_hit;
         logic w1_hit;
         logic nb_hit;

         assign w0_hit = wr.i0_wen & (wr.i0_waddr == dec_pkg::reg_addr_t'(i));
         assign w1_hit = wr.i1_wen & (wr.i1_waddr == dec_pkg::reg_addr_t'(i));
         assign nb_hit = nb_wen    & (nb_waddr    == dec_pkg::reg_addr_t'(i));

         always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
               gpr_q[i] <= '0;
            end else if (w1_hit) begin
               gpr_q[i] <= wr.i1_wdata;          // younger slot wins
            end else if (w0_hit) begin
               gpr_q[i] <= wr.i0_wdata;
            end else if (nb_hit) begin
               gpr_q[i] <= nb_wdata;             // late load data lowest
            end
         end
      end
   end

   // ******************************
   // read ports
   // ******************************
   // no write bypass, a wb write shows up the cycle after
   assign rd0 = rden0 ? gpr_q[raddr0] : '0;
   assign rd1 = rden1 ? gpr_q[raddr1] : '0;
   assign rd2 = rden2 ? gpr_q[raddr2] : '0;
   assign rd3 = rden3 ? gpr_q[raddr3] : '0;

endmodule

/* hw/dec_if.sv */
/*
 * writeback-side interfaces of the decode unit
 * gpr_wr_if carries both slot writes to the register file,
 * retire_if carries the wb retire record to the trace block
 */

interface gpr_wr_if;
   logic              i0_wen;     // slot 0 write, already qualified
   dec_pkg::reg_addr_t i0_waddr;
   dec_pkg::xlen_t     i0_wdata;
   logic              i1_wen;     // slot 1 write, wins on collision
   dec_pkg::reg_addr_t i1_waddr;
   dec_pkg::xlen_t     i1_wdata;

   modport wb_ctl (output i0_wen, i0_waddr, i0_wdata, i1_wen, i1_waddr, i1_wdata);
   modport gpr    (input  i0_wen, i0_waddr, i0_wdata, i1_wen, i1_waddr, i1_wdata);
endinterface

interface retire_if;
   logic              i0_valid;   // raw valids at wb
   logic              i1_valid;
   logic              i0_exc;     // exception taken per slot
   logic              i1_exc;
   logic              int_valid;  // interrupt taken
   dec_pkg::xlen_t     i0_instr;
   dec_pkg::xlen_t     i1_instr;
   dec_pkg::pc_t       i0_pc;
   dec_pkg::pc_t       i1_pc;
   dec_pkg::cause_t    cause;      // shared across slots
   dec_pkg::xlen_t     tval;

   modport wb_ctl (output i0_valid, i1_valid, i0_exc, i1_exc, int_valid,
                          i0_instr, i1_instr, i0_pc, i1_pc, cause, tval);
   modport trace  (input  i0_valid, i1_valid, i0_exc, i1_exc, int_valid,
                          i0_instr, i1_instr, i0_pc, i1_pc, cause, tval);
endinterface

/* hw/dec_nbload_ctl.sv */
/*
 * dec_nbload_ctl: scoreboard of outstanding non-blocking loads
 * one entry per tag, returns data to the register file on a live tag
 */

module dec_nbload_ctl #(
   parameter  int NBLOAD_TAGS = 4,                       // power of two, 2..8
   localparam int TAG_W       = $clog2(NBLOAD_TAGS)
) (
   input  logic               clk,
   input  logic               rst_n,

   input  logic               lsu_nonblock_load_valid_dc3,    // allocate
   input  logic [TAG_W-1:0]   lsu_nonblock_load_tag_dc3,
   input  dec_pkg::reg_addr_t lsu_nonblock_load_rd_dc3,       // destination
   input  logic               lsu_nonblock_load_inv_dc5,      // cancel, no write
   input  logic [TAG_W-1:0]   lsu_nonblock_load_inv_tag_dc5,
   input  logic               lsu_nonblock_load_data_valid,   // data back
   input  logic               lsu_nonblock_load_data_error,   // bus error on return
   input  logic [TAG_W-1:0]   lsu_nonblock_load_data_tag,
   input  dec_pkg::xlen_t     lsu_nonblock_load_data,

   output logic               nb_wen,
   output dec_pkg::reg_addr_t nb_waddr,
   output dec_pkg::xlen_t     nb_wdata,
   output logic               nbload_busy                     // any tag live
);

   logic [NBLOAD_TAGS-1:0] vld_q;                       // entry live
   dec_pkg::reg_addr_t     rd_q [NBLOAD_TAGS];          // destination per tag
   logic                   data_live;                   // return hits a live tag

   // ******************************
   // per-tag entries
   // ******************************
   for (genvar t = 0; t < NBLOAD_TAGS; t++) begin : g_tag
      logic set;
      logic clr;

      assign set = lsu_nonblock_load_valid_dc3 &
                   (lsu_nonblock_load_tag_dc3 == TAG_W'(t));
      assign clr = (lsu_nonblock_load_inv_dc5 &
                    (lsu_nonblock_load_inv_tag_dc5 == TAG_W'(t))) |
                   (lsu_nonblock_load_data_valid &
                    (lsu_nonblock_load_data_tag == TAG_W'(t)));  // freed on error too

      always_ff @(posedge clk or negedge rst_n) begin
         if (!rst_n) begin
            vld_q[t] <= 1'b0;
         end else if (set) begin
            vld_q[t] <= 1'b1;                           // new load reuses the tag
         end else if (clr) begin
            vld_q[t] <= 1'b0;
         end
      end

      always_ff @(posedge clk) begin
         if (set) begin
            rd_q[t] <= lsu_nonblock_load_rd_dc3;
         end
      end
   end

   // ******************************
   // write request
   // ******************************
   assign data_live = lsu_nonblock_load_data_valid & vld_q[lsu_nonblock_load_data_tag];

   assign nb_waddr  = rd_q[lsu_nonblock_load_data_tag];
   assign nb_wdata  = lsu_nonblock_load_data;
   assign nb_wen    = data_live & ~lsu_nonblock_load_data_error &
                      (nb_waddr != dec_pkg::X0);      // x0 loads just retire

   assign nbload_busy = |vld_q;

endmodule

/* hw/dec_pkg.sv */
/*
 * dec_pkg: shared types and constants of the decode register/retire path
 * register index, data word, pc, exception cause and trace vector widths
 */

package dec_pkg;

   // ******************************
   // widths with a meaning
   // ******************************
   typedef logic [4:0]  reg_addr_t;   // architectural register index
   typedef logic [31:0] xlen_t;       // data word
   typedef logic [31:1] pc_t;         // instruction address, bit 0 implied
   typedef logic [4:0]  cause_t;      // exception cause
   typedef logic [2:0]  trace_vld_t;  // {int, slot1, slot0}

   // ******************************
   // decode constants
   // ******************************
   localparam int        NUM_GPR = 32;      // x0..x31
   localparam reg_addr_t X0      = 5'd0;    // hardwired zero register

   // bit positions in a trace_vld_t
   localparam int TRC_I0  = 0;              // slot 0
   localparam int TRC_I1  = 1;              // slot 1
   localparam int TRC_INT = 2;              // interrupt

endpackage

/* hw/dec_top.sv */
/*
 * dec_top: register and retire side of the dual-issue decode unit
 * wires writeback, register file, nonblock load scoreboard and trace
 */

module dec_top #(
   parameter  int NBLOAD_TAGS = 4,                   // outstanding nonblock loads
   localparam int TAG_W       = $clog2(NBLOAD_TAGS)
) (
   input  logic                clk,
   input  logic                rst_n,

   // decode read side
   input  dec_pkg::reg_addr_t  i0_rs1,
   input  dec_pkg::reg_addr_t  i0_rs2,
   input  dec_pkg::reg_addr_t  i1_rs1,
   input  dec_pkg::reg_addr_t  i1_rs2,
   input  logic                i0_rs1_en,
   input  logic                i0_rs2_en,
   input  logic                i1_rs1_en,
   input  logic                i1_rs2_en,
   output dec_pkg::xlen_t      gpr_i0_rs1_d,
   output dec_pkg::xlen_t      gpr_i0_rs2_d,
   output dec_pkg::xlen_t      gpr_i1_rs1_d,
   output dec_pkg::xlen_t      gpr_i1_rs2_d,

   // slots at e4
   input  logic                i0_valid_e4,
   input  logic                i1_valid_e4,
   input  logic                i0_wen_e4,
   input  logic                i1_wen_e4,
   input  dec_pkg::reg_addr_t  i0_waddr_e4,
   input  dec_pkg::reg_addr_t  i1_waddr_e4,
   input  dec_pkg::xlen_t      i0_result_e4,
   input  dec_pkg::xlen_t      i1_result_e4,
   input  dec_pkg::xlen_t      i0_instr_e4,
   input  dec_pkg::xlen_t      i1_instr_e4,
   input  dec_pkg::pc_t        i0_pc_e4,
   input  dec_pkg::pc_t        i1_pc_e4,

   // exceptions at e4
   input  logic                i0_exc_e4,
   input  logic                i1_exc_e4,
   input  logic                int_valid_e4,
   input  dec_pkg::cause_t     exc_cause_e4,
   input  dec_pkg::xlen_t      mtval_e4,

   // lsu nonblock loads
   input  logic                lsu_nonblock_load_valid_dc3,
   input  logic                lsu_nonblock_load_inv_dc5,
   input  logic                lsu_nonblock_load_data_valid,
   input  logic                lsu_nonblock_load_data_error,
   input  logic [TAG_W-1:0]    lsu_nonblock_load_tag_dc3,
   input  logic [TAG_W-1:0]    lsu_nonblock_load_inv_tag_dc5,
   input  logic [TAG_W-1:0]    lsu_nonblock_load_data_tag,
   input  dec_pkg::reg_addr_t  lsu_nonblock_load_rd_dc3,
   input  dec_pkg::xlen_t      lsu_nonblock_load_data,

   output logic                nbload_busy,
   output dec_pkg::xlen_t      dec_dbg_rddata,

   // trace port, wb1
   output dec_pkg::trace_vld_t trace_valid,
   output dec_pkg::trace_vld_t trace_exception,
   output dec_pkg::trace_vld_t trace_interrupt,
   output dec_pkg::xlen_t      trace_i0_insn,
   output dec_pkg::xlen_t      trace_i1_insn,
   output dec_pkg::pc_t        trace_i0_addr,
   output dec_pkg::pc_t        trace_i1_addr,
   output dec_pkg::cause_t     trace_ecause,
   output dec_pkg::xlen_t      trace_tval
);

   gpr_wr_if wr_bus ();     // wb -> arf
   retire_if ret_bus ();    // wb -> trace

   logic               nb_wen;
   dec_pkg::reg_addr_t nb_waddr;
   dec_pkg::xlen_t     nb_wdata;

   dec_wb_ctl wb (
      .clk, .rst_n,
      .i0_valid_e4, .i1_valid_e4, .i0_wen_e4, .i1_wen_e4,
      .i0_waddr_e4, .i1_waddr_e4, .i0_result_e4, .i1_result_e4,
      .i0_instr_e4, .i1_instr_e4, .i0_pc_e4, .i1_pc_e4,
      .i0_exc_e4, .i1_exc_e4, .int_valid_e4, .exc_cause_e4, .mtval_e4,
      .wr  (wr_bus.wb_ctl),
      .ret (ret_bus.wb_ctl),
      .dec_dbg_rddata
   );

   dec_gpr_ctl arf (
      .clk, .rst_n,
      .rden0 (i0_rs1_en), .raddr0 (i0_rs1), .rd0 (gpr_i0_rs1_d),
      .rden1 (i0_rs2_en), .raddr1 (i0_rs2), .rd1 (gpr_i0_rs2_d),
      .rden2 (i1_rs1_en), .raddr2 (i1_rs1), .rd2 (gpr_i1_rs1_d),
      .rden3 (i1_rs2_en), .raddr3 (i1_rs2), .rd3 (gpr_i1_rs2_d),
      .wr    (wr_bus.gpr),
      .nb_wen, .nb_waddr, .nb_wdata
   );

   dec_nbload_ctl #(.NBLOAD_TAGS(NBLOAD_TAGS)) nbload (
      .clk, .rst_n,
      .lsu_nonblock_load_valid_dc3, .lsu_nonblock_load_tag_dc3, .lsu_nonblock_load_rd_dc3,
      .lsu_nonblock_load_inv_dc5, .lsu_nonblock_load_inv_tag_dc5,
      .lsu_nonblock_load_data_valid, .lsu_nonblock_load_data_error,
      .lsu_nonblock_load_data_tag, .lsu_nonblock_load_data,
      .nb_wen, .nb_waddr, .nb_wdata, .nbload_busy
   );

   dec_trace_ctl trace (
      .clk, .rst_n,
      .ret (ret_bus.trace),
      .trace_valid, .trace_exception, .trace_interrupt,
      .trace_i0_insn, .trace_i1_insn, .trace_i0_addr, .trace_i1_addr,
      .trace_ecause, .trace_tval
   );

endmodule

/* hw/dec_trace_ctl.sv */
/*
 * dec_trace_ctl: wb -> wb1 registers and trace field assembly
 * same packing as the core trace port, cause and tval shared by both slots
 */

module dec_trace_ctl (
   input  logic                clk,
   input  logic                rst_n,

   retire_if.trace             ret,

   output dec_pkg::trace_vld_t trace_valid,       // {int, i1, i0}
   output dec_pkg::trace_vld_t trace_exception,
   output dec_pkg::trace_vld_t trace_interrupt,   // only the int position
   output dec_pkg::xlen_t      trace_i0_insn,
   output dec_pkg::xlen_t      trace_i1_insn,
   output dec_pkg::pc_t        trace_i0_addr,
   output dec_pkg::pc_t        trace_i1_addr,
   output dec_pkg::cause_t     trace_ecause,
   output dec_pkg::xlen_t      trace_tval
);

   dec_pkg::trace_vld_t vld_wb;    // assembled at wb
   dec_pkg::trace_vld_t exc_wb;
   dec_pkg::trace_vld_t int_wb;

   // ******************************
   // field assembly at wb
   // ******************************
   always_comb begin
      vld_wb = '0;
      exc_wb = '0;
      int_wb = '0;
      vld_wb[dec_pkg::TRC_I0]  = ret.i0_valid | ret.i0_exc;   // exc counts as retired
      vld_wb[dec_pkg::TRC_I1]  = ret.i1_valid | ret.i1_exc;
      vld_wb[dec_pkg::TRC_INT] = ret.int_valid;
      exc_wb[dec_pkg::TRC_I0]  = ret.i0_exc;
      exc_wb[dec_pkg::TRC_I1]  = ret.i1_exc;
      exc_wb[dec_pkg::TRC_INT] = ret.int_valid;
      int_wb[dec_pkg::TRC_INT] = ret.int_valid;
   end

   // ******************************
   // wb1 flops
   // ******************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         trace_valid     <= '0;
         trace_exception <= '0;
         trace_interrupt <= '0;
      end else begin
         trace_valid     <= vld_wb;
         trace_exception <= exc_wb;
         trace_interrupt <= int_wb;
      end
   end

   always_ff @(posedge clk) begin
      trace_i0_insn <= ret.i0_instr;
      trace_i1_insn <= ret.i1_instr;
      trace_i0_addr <= ret.i0_pc;
      trace_i1_addr <= ret.i1_pc;
      trace_ecause  <= ret.cause;      // replicated across ports
      trace_tval    <= ret.tval;
   end

endmodule

/* hw/dec_wb_ctl.sv */
/*
 * dec_wb_ctl: e4 -> wb stage registers for both slots
 * qualifies the gpr writes with exceptions and x0, feeds trace and debug read
 */

module dec_wb_ctl (
   input  logic               clk,
   input  logic               rst_n,

   input  logic               i0_valid_e4,     // slot 0 at e4
   input  logic               i1_valid_e4,
   input  logic               i0_wen_e4,       // has a destination
   input  logic               i1_wen_e4,
   input  dec_pkg::reg_addr_t i0_waddr_e4,
   input  dec_pkg::reg_addr_t i1_waddr_e4,
   input  dec_pkg::xlen_t     i0_result_e4,
   input  dec_pkg::xlen_t     i1_result_e4,
   input  dec_pkg::xlen_t     i0_instr_e4,
   input  dec_pkg::xlen_t     i1_instr_e4,
   input  dec_pkg::pc_t       i0_pc_e4,
   input  dec_pkg::pc_t       i1_pc_e4,

   input  logic               i0_exc_e4,       // slot 0 exception
   input  logic               i1_exc_e4,       // slot 1 exception
   input  logic               int_valid_e4,    // interrupt taken at e4
   input  dec_pkg::cause_t    exc_cause_e4,
   input  dec_pkg::xlen_t     mtval_e4,

   gpr_wr_if.wb_ctl           wr,
   retire_if.wb_ctl           ret,

   output dec_pkg::xlen_t     dec_dbg_rddata   // slot 0 wb data
);

   logic i0_wen_q_e4;       // qualified write, slot 0
   logic i1_wen_q_e4;       // qualified write, slot 1

   // ******************************
   // write qualification at e4
   // ******************************
   // an older exception kills the younger slot as well
   assign i0_wen_q_e4 = i0_valid_e4 & i0_wen_e4 & ~i0_exc_e4 &
                        (i0_waddr_e4 != dec_pkg::X0);
   assign i1_wen_q_e4 = i1_valid_e4 & i1_wen_e4 & ~i0_exc_e4 & ~i1_exc_e4 &
                        (i1_waddr_e4 != dec_pkg::X0);

   // ******************************
   // wb control flops
   // ******************************
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr.i0_wen     <= 1'b0;
         wr.i1_wen     <= 1'b0;
         ret.i0_valid  <= 1'b0;
         ret.i1_valid  <= 1'b0;
         ret.i0_exc    <= 1'b0;
         ret.i1_exc    <= 1'b0;
         ret.int_valid <= 1'b0;
      end else begin
         wr.i0_wen     <= i0_wen_q_e4;
         wr.i1_wen     <= i1_wen_q_e4;
         ret.i0_valid  <= i0_valid_e4;
         ret.i1_valid  <= i1_valid_e4;
         ret.i0_exc    <= i0_exc_e4;
         ret.i1_exc    <= i1_exc_e4;
         ret.int_valid <= int_valid_e4;
      end
   end

   // ******************************
   // wb payload flops
   // ******************************
   always_ff @(posedge clk) begin
      wr.i0_waddr  <= i0_waddr_e4;
      wr.i0_wdata  <= i0_result_e4;    // alu result becomes wb data
      wr.i1_waddr  <= i1_waddr_e4;
      wr.i1_wdata  <= i1_result_e4;
      ret.i0_instr <= i0_instr_e4;
      ret.i1_instr <= i1_instr_e4;
      ret.i0_pc    <= i0_pc_e4;
      ret.i1_pc    <= i1_pc_e4;
      ret.cause    <= exc_cause_e4;
      ret.tval     <= mtval_e4;
   end

   assign dec_dbg_rddata = wr.i0_wdata;   // debug abstract cmd reads slot 0 data

endmodule

/* run.sh */
#!/bin/sh
# build the dec_top testbench with verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module dec_tb -f tb.f -o dec_tb_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/dec_tb_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

if grep -q "SOME TESTS FAILED" sim.log; then
   exit 1
fi
exit 0

/* tb.f */
hw/dec_pkg.sv
hw/dec_if.sv
hw/dec_wb_ctl.sv
hw/dec_gpr_ctl.sv
hw/dec_nbload_ctl.sv
hw/dec_trace_ctl.sv
hw/dec_top.sv
tb/dec_chk.sv
tb/dec_tb.sv

/* tb/dec_chk.sv */
/*
 * dec_chk: concurrent checks on dec_top internals, bound into dec_top
 */

module dec_chk (
   input logic               clk,
   input logic               rst_n,
   input logic               nb_wen,
   input dec_pkg::reg_addr_t nb_waddr,
   input logic               nbload_busy,
   input logic               wr_i1_wen,     // slot 1 write at wb
   input logic               ret_i0_exc     // slot 0 exception at wb
);

   // a load to x0 retires without a gpr write
   a_nb_x0: assert property (@(posedge clk) disable iff (!rst_n)
                             nb_wen |-> (nb_waddr != dec_pkg::X0))
      else $error("nonblock load write targets x0");

   a_busy_rst: assert property (@(posedge clk) $rose(rst_n) |-> !nbload_busy)
      else $error("nbload_busy high right after reset");

   // older exception kills the younger slot
   a_i1_kill: assert property (@(posedge clk) disable iff (!rst_n)
                               !(wr_i1_wen && ret_i0_exc))
      else $error("slot 1 write alongside slot 0 exception");

endmodule

bind dec_top dec_chk chk_inst (
   .clk, .rst_n, .nb_wen, .nb_waddr, .nbload_busy,
   .wr_i1_wen  (wr_bus.i1_wen),
   .ret_i0_exc (ret_bus.i0_exc)
);

/* tb/dec_tb.sv */
/*
 * dec_tb: table driven testbench for the decode register and retire path
 * reference gpr and load tag model, checks reads, debug data, trace and busy
 */

module dec_tb;

   // ******************************
   // stimulus and expected values
   // ******************************
   typedef struct packed {
      logic [6:0]         ctl;        // {v0, v1, wen0, wen1, exc0, exc1, int}
      dec_pkg::reg_addr_t a0;         // slot write addresses
      dec_pkg::reg_addr_t a1;
      logic [3:0]         ren;        // {i0_rs1, i0_rs2, i1_rs1, i1_rs2}
      dec_pkg::reg_addr_t r0;
      dec_pkg::reg_addr_t r1;
      dec_pkg::reg_addr_t r2;
      dec_pkg::reg_addr_t r3;
      logic [3:0]         nbc;        // {alloc, inv, data, error}
      logic [1:0]         tal;        // alloc tag
      logic [1:0]         tinv;       // invalidate tag
      logic [1:0]         tdat;       // data return tag
      dec_pkg::reg_addr_t nrd;        // load destination
   } stim_t;

   typedef struct packed {
      stim_t                s;
      dec_pkg::xlen_t       d0, d1, nbd, ins0, ins1, tval;
      dec_pkg::pc_t         pc0, pc1;
      dec_pkg::cause_t      cause;
      dec_pkg::xlen_t [3:0] xrd;      // expected read data, port 0 first
      dec_pkg::trace_vld_t  xvld, xexc, xint;
      logic                 xbusy;
   } row_t;

   logic clk, rst_n, nbload_busy;
   logic i0_rs1_en, i0_rs2_en, i1_rs1_en, i1_rs2_en;
   logic i0_valid_e4, i1_valid_e4, i0_wen_e4, i1_wen_e4, i0_exc_e4, i1_exc_e4, int_valid_e4;
   logic lsu_nonblock_load_valid_dc3, lsu_nonblock_load_inv_dc5;
   logic lsu_nonblock_load_data_valid, lsu_nonblock_load_data_error;
   logic [1:0] lsu_nonblock_load_tag_dc3, lsu_nonblock_load_inv_tag_dc5;
   logic [1:0] lsu_nonblock_load_data_tag;
   dec_pkg::reg_addr_t i0_rs1, i0_rs2, i1_rs1, i1_rs2, i0_waddr_e4, i1_waddr_e4;
   dec_pkg::reg_addr_t lsu_nonblock_load_rd_dc3;
   dec_pkg::xlen_t gpr_i0_rs1_d, gpr_i0_rs2_d, gpr_i1_rs1_d, gpr_i1_rs2_d;
   dec_pkg::xlen_t i0_result_e4, i1_result_e4, i0_instr_e4, i1_instr_e4, mtval_e4;
   dec_pkg::xlen_t lsu_nonblock_load_data, dec_dbg_rddata;
   dec_pkg::xlen_t trace_i0_insn, trace_i1_insn, trace_tval;
   dec_pkg::pc_t i0_pc_e4, i1_pc_e4, trace_i0_addr, trace_i1_addr;
   dec_pkg::cause_t exc_cause_e4, trace_ecause;
   dec_pkg::trace_vld_t trace_valid, trace_exception, trace_interrupt;

   dec_pkg::xlen_t     ref_gpr [32];   // architectural state model
   dec_pkg::reg_addr_t live_rd [4];    // destination per tag
   logic [3:0]         live;           // tags outstanding
   row_t               tbl [$];
   int seed = 26596;
   int errors = 0, row_err = 0, passed = 0, ntests = 0, cycles = 0, limit = 0;

   dec_top #(.NBLOAD_TAGS(4)) dec_top_inst (.*);

   always #2 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > limit) begin
         $display("timeout: no progress after %0d cycles", cycles);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   // builds one row and advances the reference model by it
   task automatic add_row(input stim_t s);
      row_t               r;
      logic [63:0]        rnd;
      dec_pkg::reg_addr_t ra;
      logic [6:0]         c;
      r      = '0;
      r.s    = s;
      c      = s.ctl;
      r.d0   = $random(seed);
      r.d1   = $random(seed);
      r.nbd  = $random(seed);
      r.ins0 = $random(seed);
      r.ins1 = $random(seed);
      r.tval = $random(seed);
      rnd    = {$random(seed), $random(seed)};
      r.pc0  = rnd[30:0];
      r.pc1  = rnd[61:31];
      r.cause = r.tval[9:5];
      // load return lands one edge before the slot writes
      if (s.nbc[1] && live[s.tdat] && !s.nbc[0]) ref_gpr[live_rd[s.tdat]] = r.nbd;
      if (s.nbc[2]) live[s.tinv] = 1'b0;
      if (s.nbc[1]) live[s.tdat] = 1'b0;        // freed on error too
      if (s.nbc[3]) begin
         live[s.tal]    = 1'b1;
         live_rd[s.tal] = s.nrd;
      end
      if (c[6] && c[4] && !c[2]) ref_gpr[s.a0] = r.d0;
      if (c[5] && c[3] && !c[2] && !c[1]) ref_gpr[s.a1] = r.d1;   // slot 1 last, wins
      for (int p = 0; p < 4; p++) begin
         ra = (p == 0) ? s.r0 : (p == 1) ? s.r1 : (p == 2) ? s.r2 : s.r3;
         r.xrd[p] = (s.ren[3-p] && ra != 0) ? ref_gpr[ra] : '0;   // x0 and off read zero
      end
      r.xvld  = {c[0], c[5] | c[1], c[6] | c[2]};
      r.xexc  = {c[0], c[1], c[2]};              // interrupt is an exception input too
      r.xint  = {c[0], 2'b00};
      r.xbusy = |live;
      tbl.push_back(r);
   endtask

   task automatic drive(input row_t r);
      {i0_valid_e4, i1_valid_e4, i0_wen_e4, i1_wen_e4, i0_exc_e4, i1_exc_e4,
       int_valid_e4} = r.s.ctl;
      i0_waddr_e4  = r.s.a0;
      i1_waddr_e4  = r.s.a1;
      i0_result_e4 = r.d0;
      i1_result_e4 = r.d1;
      i0_instr_e4  = r.ins0;
      i1_instr_e4  = r.ins1;
      i0_pc_e4     = r.pc0;
      i1_pc_e4     = r.pc1;
      exc_cause_e4 = r.cause;
      mtval_e4     = r.tval;
      {i0_rs1_en, i0_rs2_en, i1_rs1_en, i1_rs2_en} = r.s.ren;
      i0_rs1 = r.s.r0;
      i0_rs2 = r.s.r1;
      i1_rs1 = r.s.r2;
      i1_rs2 = r.s.r3;
      {lsu_nonblock_load_valid_dc3, lsu_nonblock_load_inv_dc5, lsu_nonblock_load_data_valid,
       lsu_nonblock_load_data_error} = r.s.nbc;
      lsu_nonblock_load_tag_dc3     = r.s.tal;
      lsu_nonblock_load_inv_tag_dc5 = r.s.tinv;
      lsu_nonblock_load_data_tag    = r.s.tdat;
      lsu_nonblock_load_rd_dc3      = r.s.nrd;
      lsu_nonblock_load_data        = r.nbd;
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         errors++;
         row_err++;
         $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
      end
   endtask

   task automatic print_result(input string name);
      ntests++;
      if (row_err == 0) begin
         passed++;
         $display("%s ok", name);
      end else begin
         $display("%s failed with %0d mismatches", name, row_err);
      end
   endtask

   initial begin
      row_t        r;
      row_t        idle;
      logic [63:0] rnd;
      clk   = 1'b0;
      rst_n = 1'b0;
      drive('0);
      foreach (ref_gpr[k]) ref_gpr[k] = '0;
      live = '0;
      // ctl, a0, a1, ren, rs1/rs2 of i0 then i1, nbc, tal, tinv, tdat, nrd
      add_row('{'b1010000, 3, 0, 'b1000, 3, 0, 0, 0, 'b0000, 0, 0, 0, 0});
      add_row('{'b0101000, 0, 5, 'b0110, 0, 3, 5, 0, 'b0000, 0, 0, 0, 0});
      add_row('{'b1111000, 7, 7, 'b1001, 7, 0, 0, 7, 'b0000, 0, 0, 0, 0});   // collision
      add_row('{'b1111000, 0, 0, 'b1010, 0, 7, 7, 3, 'b0000, 0, 0, 0, 0});   // x0, en low
      add_row('{'b1111100, 9, 10, 'b1100, 9, 10, 0, 0, 'b0000, 0, 0, 0, 0}); // i0 exception
      add_row('{'b1111010, 9, 10, 'b1100, 9, 10, 0, 0, 'b0000, 0, 0, 0, 0}); // i1 exception
      add_row('{'b0000001, 0, 0, 'b1000, 9, 0, 0, 0, 'b0000, 0, 0, 0, 0});   // interrupt
      add_row('{'b1010000, 11, 0, 'b1100, 11, 12, 0, 0, 'b1000, 1, 0, 0, 12});
      add_row('{'b0000000, 0, 0, 'b1000, 12, 0, 0, 0, 'b1000, 2, 0, 0, 13});
      add_row('{'b0000000, 0, 0, 'b1000, 12, 0, 0, 0, 'b0010, 0, 0, 1, 0});  // data tag 1
      add_row('{'b0000000, 0, 0, 'b1000, 13, 0, 0, 0, 'b0100, 0, 2, 0, 0});  // inv tag 2
      add_row('{'b0000000, 0, 0, 'b0001, 0, 0, 0, 14, 'b1000, 3, 0, 0, 14});
      add_row('{'b0000000, 0, 0, 'b0001, 0, 0, 0, 14, 'b0011, 0, 0, 3, 0});  // error return
      add_row('{'b0000000, 0, 0, 'b1000, 12, 0, 0, 0, 'b0010, 0, 0, 1, 0});  // dead tag
      add_row('{'b0000000, 0, 0, 'b1000, 13, 0, 0, 0, 'b0010, 0, 0, 2, 0});  // invalidated tag
      for (int k = 0; k < 10; k++) begin
         rnd = {$random(seed), $random(seed)};
         add_row(rnd[$bits(stim_t)-1:0]);
      end
      limit = tbl.size() * 4 + 10 + 50;      // rows, reset, margin

      repeat (10) @(negedge clk);
      check_value("nbload_busy", 32'(nbload_busy), 0);
      check_value("trace_valid", 32'(trace_valid), 0);
      check_value("trace_exception", 32'(trace_exception), 0);
      check_value("trace_interrupt", 32'(trace_interrupt), 0);
      print_result("reset");
      rst_n = 1'b1;

      foreach (tbl[i]) begin
         r       = tbl[i];
         row_err = 0;
         @(negedge clk);
         drive(r);                           // e4 cycle
         idle       = r;
         idle.s.ctl = '0;
         idle.s.nbc = '0;
         @(negedge clk);
         drive(idle);                        // wb, read addresses held
         check_value("dec_dbg_rddata", dec_dbg_rddata, r.d0);
         @(negedge clk);                     // wb1
         check_value("gpr_i0_rs1_d", gpr_i0_rs1_d, r.xrd[0]);
         check_value("gpr_i0_rs2_d", gpr_i0_rs2_d, r.xrd[1]);
         check_value("gpr_i1_rs1_d", gpr_i1_rs1_d, r.xrd[2]);
         check_value("gpr_i1_rs2_d", gpr_i1_rs2_d, r.xrd[3]);
         check_value("trace_valid", 32'(trace_valid), 32'(r.xvld));
         check_value("trace_exception", 32'(trace_exception), 32'(r.xexc));
         check_value("trace_interrupt", 32'(trace_interrupt), 32'(r.xint));
         check_value("trace_i0_insn", trace_i0_insn, r.ins0);
         check_value("trace_i1_insn", trace_i1_insn, r.ins1);
         check_value("trace_i0_addr", 32'(trace_i0_addr), 32'(r.pc0));
         check_value("trace_i1_addr", 32'(trace_i1_addr), 32'(r.pc1));
         check_value("trace_ecause", 32'(trace_ecause), 32'(r.cause));
         check_value("trace_tval", trace_tval, r.tval);
         check_value("nbload_busy", 32'(nbload_busy), 32'(r.xbusy));
         print_result($sformatf("row %0d", i));
      end

      $display("%0d of %0d tests passed, %0d mismatches", passed, ntests, errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule
